/* Bender.yml */
package:
  name: i2c_master

sources:
  # design, in compile order
  - design/i2c_pkg.sv
  - design/i2c_cmd_if.sv
  - design/i2c_line_if.sv
  - design/i2c_cmd_capture.sv
  - design/i2c_bit_sequencer.sv
  - design/i2c_line_io.sv
  - design/i2c_master.sv

  # testbench and bound assertions
  - target: test
    files:
      - tests/i2c_master_properties.sv
      - tests/i2c_master_tb.sv

/* design/i2c_bit_sequencer.sv */
`timescale 1ns/1ps

module i2c_bit_sequencer import i2c_pkg::*; #(
    parameter int CLKS_PER_PHASE = 1
) (
    input  logic       clk,
    input  logic       reset_p,
    i2c_cmd_if.sink    cmd,
    i2c_line_if.source line,
    output logic       o_busy
);

    localparam int CNT_W = (CLKS_PER_PHASE > 1) ? $clog2(CLKS_PER_PHASE) : 1;
    localparam int IDX_W = $clog2(DATA_W);

    i2c_state_e        state;
    logic [CNT_W-1:0]  phase_cnt;
    logic [1:0]        phase;
    logic [IDX_W-1:0]  bit_idx;
    data_t             tx_shift;
    logic              phase_last;
    logic              slot_last;
    logic              scl_pulse;

    assign phase_last = (phase_cnt == CNT_W'(CLKS_PER_PHASE - 1));
    assign slot_last  = phase_last && (phase == 2'(PHASES_PER_BIT - 1));

    // scl is high in the middle two phases of a normal slot
    assign scl_pulse = phase[1] ^ phase[0];

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            state     <= ST_IDLE;
            phase_cnt <= '0;
            phase     <= '0;
            bit_idx   <= '0;
        end else if (state == ST_IDLE) begin
            phase_cnt <= '0;
            phase     <= '0;
            bit_idx   <= '0;
            if (cmd.start) begin
                state <= ST_START;
            end
        end else begin
            phase_cnt <= phase_last ? '0 : phase_cnt + 1'b1;
            if (phase_last) begin
                phase <= phase + 1'b1;
            end
            if (slot_last) begin
                case (state)
                    ST_START: begin
                        state <= ST_ADDR;
                    end
                    ST_ADDR: begin
                        if (bit_idx == IDX_W'(ADDR_W - 1)) begin
                            bit_idx <= '0;
                            state   <= ST_RW;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                    ST_RW: begin
                        state <= ST_ACK1;
                    end
                    ST_ACK1: begin
                        state <= (cmd.rw == RW_READ) ? ST_READ : ST_WRITE;
                    end
                    ST_WRITE, ST_READ: begin
                        if (bit_idx == IDX_W'(DATA_W - 1)) begin
                            bit_idx <= '0;
                            state   <= ST_ACK2;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                    ST_ACK2: begin
                        state <= ST_STOP;
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // address and rw go out of one shifter, data is loaded after the first ack
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cmd.start) begin
            tx_shift <= {cmd.addr, cmd.rw};
        end else if (slot_last && state == ST_ACK1) begin
            tx_shift <= cmd.data;
        end else if (slot_last && (state inside {ST_ADDR, ST_RW, ST_WRITE})) begin
            tx_shift <= {tx_shift[DATA_W-2:0], 1'b0};
        end
    end

    always_comb begin
        line.scl_level   = 1'b1;
        line.sda_release = 1'b1;
        case (state)
            ST_IDLE: begin
                line.scl_level   = 1'b1;
                line.sda_release = 1'b1;
            end
            ST_START: begin
                // sda falls in phase 2 while scl is still high
                line.scl_level   = scl_pulse;
                line.sda_release = !phase[1];
            end
            ST_STOP: begin
                // scl stays high from phase 1 on, sda rises in phase 2
                line.scl_level   = (phase != 2'd0);
                line.sda_release = phase[1];
            end
            ST_ADDR, ST_RW, ST_WRITE: begin
                line.scl_level   = scl_pulse;
                line.sda_release = tx_shift[DATA_W-1];
            end
            default: begin
                // ack and read slots leave sda to the slave
                line.scl_level   = scl_pulse;
                line.sda_release = 1'b1;
            end
        endcase
    end

    assign line.sample  = (state == ST_READ) && (phase == 2'd2) && phase_last;
    assign line.rx_done = (state == ST_STOP) && slot_last && (cmd.rw == RW_READ);

    assign o_busy = (state != ST_IDLE);

endmodule

/* design/i2c_cmd_capture.sv */
`timescale 1ns/1ps

module i2c_cmd_capture import i2c_pkg::*; (
    input  logic      clk,
    input  logic      reset_p,
    input  addr_t     i_addr,
    input  data_t     i_data,
    input  i2c_rw_e   i_rw,
    input  logic      i_valid,
    input  logic      i_busy,
    i2c_cmd_if.source cmd
);

    logic start_q;
    logic accept;

    // the strobe cycle counts as pending, busy only rises one cycle later
    assign accept = i_valid && !i_busy && !start_q;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            start_q <= 1'b0;
        end else begin
            start_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.addr <= i_addr;
            cmd.data <= i_data;
            cmd.rw   <= i_rw;
        end
    end

    assign cmd.start = start_q;

endmodule

/* design/i2c_cmd_if.sv */
`timescale 1ns/1ps

interface i2c_cmd_if import i2c_pkg::*; ();

    // one-cycle strobe, payload stays put until the next accepted request
    logic    start;
    addr_t   addr;
    data_t   data;
    i2c_rw_e rw;

    modport source (
        output start,
        output addr,
        output data,
        output rw
    );

    modport sink (
        input start,
        input addr,
        input data,
        input rw
    );

endinterface

/* design/i2c_line_if.sv */
`timescale 1ns/1ps

interface i2c_line_if ();

    logic scl_level;
    // high releases sda, low pulls it down
    logic sda_release;
    logic sample;
    logic rx_done;

    modport source (
        output scl_level,
        output sda_release,
        output sample,
        output rx_done
    );

    modport sink (
        input scl_level,
        input sda_release,
        input sample,
        input rx_done
    );

endinterface

/* design/i2c_line_io.sv */
`timescale 1ns/1ps

module i2c_line_io import i2c_pkg::*; (
    input  logic     clk,
    input  logic     reset_p,
    i2c_line_if.sink line,
    output logic     o_scl,
    inout  wire      o_sda,
    output data_t    o_rx_data,
    output logic     o_rx_valid
);

    logic  sda_rel_q;
    data_t rx_shift;

    // pin registers, bus idles with both lines high
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            o_scl     <= 1'b1;
            sda_rel_q <= 1'b1;
        end else begin
            o_scl     <= line.scl_level;
            sda_rel_q <= line.sda_release;
        end
    end

    // open drain, the high level comes from the pull-up
    assign o_sda = sda_rel_q ? 1'bz : 1'b0;

    // msb arrives first
    always_ff @(posedge clk) begin
        if (line.sample) begin
            rx_shift <= {rx_shift[DATA_W-2:0], o_sda};
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            o_rx_data  <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= line.rx_done;
            if (line.rx_done) begin
                o_rx_data <= rx_shift;
            end
        end
    end

endmodule

/* design/i2c_master.sv */
`timescale 1ns/1ps

module i2c_master import i2c_pkg::*; #(
    parameter int CLKS_PER_PHASE = 1
) (
    input  logic    clk,
    input  logic    reset_p,
    input  addr_t   i_addr,
    input  data_t   i_data,
    input  i2c_rw_e i_rw,
    input  logic    i_valid,
    inout  wire     o_sda,
    output logic    o_scl,
    output logic    o_busy,
    output data_t   o_rx_data,
    output logic    o_rx_valid
);

    i2c_cmd_if  u_cmd_if ();
    i2c_line_if u_line_if ();

    // request side
    i2c_cmd_capture u_cmd_capture (
        .clk     (clk),
        .reset_p (reset_p),
        .i_addr  (i_addr),
        .i_data  (i_data),
        .i_rw    (i_rw),
        .i_valid (i_valid),
        .i_busy  (o_busy),
        .cmd     (u_cmd_if.source)
    );

    // frame sequencing
    i2c_bit_sequencer #(
        .CLKS_PER_PHASE (CLKS_PER_PHASE)
    ) u_bit_sequencer (
        .clk     (clk),
        .reset_p (reset_p),
        .cmd     (u_cmd_if.sink),
        .line    (u_line_if.source),
        .o_busy  (o_busy)
    );

    // pins and receive data
    i2c_line_io u_line_io (
        .clk        (clk),
        .reset_p    (reset_p),
        .line       (u_line_if.sink),
        .o_scl      (o_scl),
        .o_sda      (o_sda),
        .o_rx_data  (o_rx_data),
        .o_rx_valid (o_rx_valid)
    );

endmodule

/* design/i2c_pkg.sv */
package i2c_pkg;

    // bus field widths
    localparam int ADDR_W = 7;
    localparam int DATA_W = 8;

    // one bit slot is cut into four quarter phases
    localparam int PHASES_PER_BIT = 4;

    // start, 7 address, rw, ack, 8 data, ack, stop
    localparam int SLOTS_PER_FRAME = 20;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // value is the bit that goes out in the rw slot
    typedef enum logic {
        RW_WRITE = 1'b0,
        RW_READ  = 1'b1
    } i2c_rw_e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_ADDR,
        ST_RW,
        ST_ACK1,
        ST_WRITE,
        ST_READ,
        ST_ACK2,
        ST_STOP
    } i2c_state_e;

endpackage

/* i2c_master.f */
design/i2c_pkg.sv
design/i2c_cmd_if.sv
design/i2c_line_if.sv
design/i2c_cmd_capture.sv
design/i2c_bit_sequencer.sv
design/i2c_line_io.sv
design/i2c_master.sv
tests/i2c_master_properties.sv
tests/i2c_master_tb.sv

/* tests/i2c_master_properties.sv */
`timescale 1ns/1ps

module i2c_master_properties #(
    parameter int CLKS_PER_PHASE = 1
) (
    input logic clk,
    input logic reset_p,
    input logic i_scl,
    input logic i_sda,
    input logic i_busy,
    input logic i_rx_valid
);

    localparam int FRAME_CLKS = 80 * CLKS_PER_PHASE;
    localparam int SLOT_CLKS  = 4 * CLKS_PER_PHASE;

    // busy cycles in a row before the current edge
    int unsigned busy_cnt;

    // number of failed assertions so far
    int unsigned fail_cnt = 0;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            busy_cnt <= 0;
        end else begin
            busy_cnt <= i_busy ? busy_cnt + 1 : 0;
        end
    end

    scl_high_when_idle: assert property (@(posedge clk) disable iff (reset_p)
        !i_busy |-> i_scl)
        else begin
            fail_cnt++;
            $error("scl is low while the master is idle");
        end

    rx_valid_after_frame: assert property (@(posedge clk) disable iff (reset_p)
        i_rx_valid |-> !i_busy && $past(i_busy))
        else begin
            fail_cnt++;
            $error("rx_valid outside the first idle cycle");
        end

    // sda may only fall under a high scl in the start slot
    sda_fall_only_at_start: assert property (@(posedge clk) disable iff (reset_p)
        (i_scl && $past(i_scl) && $fell(i_sda)) |-> (i_busy && busy_cnt <= SLOT_CLKS))
        else begin
            fail_cnt++;
            $error("sda fell while scl was high outside a start");
        end

    sda_rise_only_at_stop: assert property (@(posedge clk) disable iff (reset_p)
        (i_scl && $past(i_scl) && $rose(i_sda)) |->
            (i_busy && busy_cnt >= FRAME_CLKS - SLOT_CLKS))
        else begin
            fail_cnt++;
            $error("sda rose while scl was high outside a stop");
        end

    busy_length: assert property (@(posedge clk) disable iff (reset_p)
        i_busy |-> busy_cnt < FRAME_CLKS)
        else begin
            fail_cnt++;
            $error("busy lasted longer than one frame");
        end

endmodule

bind i2c_master i2c_master_properties #(
    .CLKS_PER_PHASE (CLKS_PER_PHASE)
) u_properties (
    .clk        (clk),
    .reset_p    (reset_p),
    .i_scl      (o_scl),
    .i_sda      (o_sda),
    .i_busy     (o_busy),
    .i_rx_valid (o_rx_valid)
);

/* tests/i2c_master_tb.sv */
`timescale 1ns/1ps

module i2c_master_tb import i2c_pkg::*; ();

    localparam int CLKS_PER_PHASE = 2;
    localparam int BUSY_CLKS      = 80 * CLKS_PER_PHASE;
    localparam int FRAME_BITS     = 19;
    localparam int NUM_REQUESTS   = 12;
    localparam int WAIT_LIMIT     = 4 * BUSY_CLKS;

    logic    clk;
    logic    reset_p;
    addr_t   i_addr;
    data_t   i_data;
    i2c_rw_e i_rw;
    logic    i_valid;
    wire     sda;
    logic    o_scl;
    logic    o_busy;
    data_t   o_rx_data;
    logic    o_rx_valid;

    logic [31:0]           rng_state;
    logic                  slave_pull;
    logic                  slave_reading;
    data_t                 slave_byte;
    data_t                 rx_byte_held;
    logic                  in_frame;
    logic                  frame_bits[$];
    logic [FRAME_BITS-1:0] last_frame;
    int                    last_frame_len;
    int                    frames_done;

    i2c_master #(
        .CLKS_PER_PHASE (CLKS_PER_PHASE)
    ) u_dut (
        .clk        (clk),
        .reset_p    (reset_p),
        .i_addr     (i_addr),
        .i_data     (i_data),
        .i_rw       (i_rw),
        .i_valid    (i_valid),
        .o_sda      (sda),
        .o_scl      (o_scl),
        .o_busy     (o_busy),
        .o_rx_data  (o_rx_data),
        .o_rx_valid (o_rx_valid)
    );

    pullup (sda);
    assign sda = slave_pull ? 1'b0 : 1'bz;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            report_failure($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // the bound pin assertions count their failures
    always @(negedge clk) begin
        assert (u_dut.u_properties.fail_cnt == 0) else begin
            report_failure("a bound assertion on the bus pins failed");
        end
    end

    // slave model: start, stop and bit capture on the scl rise
    always @(negedge sda) begin
        if (o_scl === 1'b1) begin
            in_frame = 1'b1;
            frame_bits.delete();
        end
    end

    always @(posedge sda) begin
        if (o_scl === 1'b1 && in_frame) begin
            in_frame       = 1'b0;
            last_frame_len = frame_bits.size();
            last_frame     = '0;
            foreach (frame_bits[i]) begin
                if (i < FRAME_BITS) begin
                    last_frame[FRAME_BITS-1-i] = frame_bits[i];
                end
            end
            frames_done++;
        end
    end

    always @(posedge o_scl) begin
        if (in_frame) begin
            frame_bits.push_back(sda);
        end
    end

    // after the first ack of a read the slave puts out its byte, msb first
    always @(negedge o_scl) begin
        if (in_frame && frame_bits.size() >= 9 && frame_bits.size() <= 16
                && frame_bits[7] === 1'b1) begin
            slave_pull    = !slave_byte[16 - frame_bits.size()];
            slave_reading = 1'b1;
        end else begin
            slave_pull    = 1'b0;
            slave_reading = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (slave_reading && !slave_pull) begin
            check_value("sda in read slot", sda, 1'b1);
        end
    end

    task automatic drive_junk_request();
        logic [31:0] r;
        r       = next_random();
        i_addr  = r[6:0];
        i_data  = r[15:8];
        i_rw    = i2c_rw_e'(r[16]);
        i_valid = 1'b1;
    endtask

    task automatic run_request(input i2c_rw_e rw);
        logic [31:0]           r;
        addr_t                 addr;
        data_t                 data;
        int                    busy_cycles;
        int                    junk_at;
        int                    frames_before;
        int                    waited;
        logic [FRAME_BITS-1:0] expected;
        r             = next_random();
        addr          = r[6:0];
        data          = r[15:8];
        slave_byte    = r[23:16];
        junk_at       = 1 + (next_random() % (BUSY_CLKS - 10));
        frames_before = frames_done;
        i_addr        = addr;
        i_data        = data;
        i_rw          = rw;
        i_valid       = 1'b1;
        @(negedge clk);
        // lands in the start strobe cycle and must be ignored
        drive_junk_request();
        check_value("o_busy", o_busy, 1'b0);
        @(negedge clk);
        i_valid = 1'b0;
        check_value("o_busy", o_busy, 1'b1);
        busy_cycles = 0;
        while (o_busy) begin
            busy_cycles++;
            check_value("o_rx_valid", o_rx_valid, 1'b0);
            if (busy_cycles > WAIT_LIMIT) begin
                report_failure("timeout: o_busy never fell after the request");
            end
            @(negedge clk);
            i_valid = 1'b0;
            if (busy_cycles == junk_at) begin
                drive_junk_request();
            end
        end
        check_value("busy cycles", busy_cycles, BUSY_CLKS);
        check_value("o_rx_valid", o_rx_valid, rw == RW_READ);
        // a write frame leaves the last received byte in place
        if (rw == RW_READ) begin
            rx_byte_held = slave_byte;
        end
        check_value("o_rx_data", o_rx_data, rx_byte_held);
        @(negedge clk);
        check_value("o_rx_valid", o_rx_valid, 1'b0);
        waited = 0;
        while (frames_done == frames_before) begin
            if (waited > WAIT_LIMIT) begin
                report_failure("timeout: the slave model never saw a STOP");
            end
            @(negedge clk);
            waited++;
        end
        // address, rw, released ack, byte, released ack, low sda under the stop rise
        expected = {addr, rw, 1'b1, (rw == RW_READ) ? slave_byte : data, 1'b1, 1'b0};
        check_value("frame length", last_frame_len, FRAME_BITS);
        check_value("sda frame bits", last_frame, expected);
        repeat (4) begin
            @(negedge clk);
            check_value("o_busy", o_busy, 1'b0);
        end
        check_value("frames seen", frames_done, frames_before + 1);
    endtask

    initial begin
        logic [31:0] r;
        rng_state      = 32'h9f9b_ee22;
        reset_p        = 1'b1;
        i_addr         = '0;
        i_data         = '0;
        i_rw           = RW_WRITE;
        i_valid        = 1'b0;
        slave_pull     = 1'b0;
        slave_reading  = 1'b0;
        slave_byte     = '0;
        rx_byte_held   = '0;
        in_frame       = 1'b0;
        last_frame     = '0;
        last_frame_len = 0;
        frames_done    = 0;
        repeat (2) @(negedge clk);
        reset_p = 1'b0;
        @(negedge clk);
        check_value("o_busy", o_busy, 1'b0);
        check_value("o_rx_valid", o_rx_valid, 1'b0);
        check_value("o_rx_data", o_rx_data, 8'h00);
        check_value("o_scl", o_scl, 1'b1);
        check_value("sda", sda, 1'b1);
        for (int i = 0; i < NUM_REQUESTS; i++) begin
            r = next_random();
            // first a write, then a read, then random directions
            run_request(i < 2 ? i2c_rw_e'(i[0]) : i2c_rw_e'(r[0]));
            repeat (r[5:4]) @(negedge clk);
        end
        if (u_dut.u_properties.fail_cnt == 0) begin
            $display("test passed");
            $finish;
        end else begin
            report_failure("a bound assertion on the bus pins failed");
        end
    end

endmodule
